//--- design/cipher_ctrl_pkg.sv
// AES cipher round sequencer package
// Sparse handshake codes, key lengths, round counts and rail FSM states

package cipher_ctrl_pkg;

  ////////////////////
  // Sparse encoding
  ////////////////////

  // One control rail per bit of the sparse code
  localparam int unsigned Sp2VWidth = 3;

  // Two-valued sparse signal, all other codes are invalid
  typedef enum logic [Sp2VWidth-1:0] {
    SP2V_HIGH = 3'b011,
    SP2V_LOW  = 3'b100
  } sp2v_e;

  // Bit i set means rail i carries positive polarity
  localparam logic [Sp2VWidth-1:0] SP2V_LOGIC_HIGH = SP2V_HIGH;

  ////////////////////
  // Configuration
  ////////////////////

  typedef enum logic {
    CIPH_FWD = 1'b0, // Encrypt
    CIPH_INV = 1'b1  // Decrypt
  } ciph_op_e;

  typedef enum logic [2:0] {
    AES_128 = 3'b001,
    AES_192 = 3'b010,
    AES_256 = 3'b100
  } key_len_e;

  typedef logic [3:0] round_t;

  localparam round_t NumRounds128 = 4'd10;
  localparam round_t NumRounds192 = 4'd12;
  localparam round_t NumRounds256 = 4'd14;

  // Rail FSM states, ERROR is terminal until reset
  typedef enum logic [2:0] {
    IDLE   = 3'b001,
    ROUND  = 3'b010,
    FINISH = 3'b100,
    ERROR  = 3'b111
  } rail_state_e;

endpackage

//--- design/rail_if.sv
// Control rail output bundle
// Carries one rail's handshake bits, round counter and alert to the combiner

`timescale 1ns/10ps

interface rail_if import cipher_ctrl_pkg::*; ();

  logic   in_ready;  // Rail polarity
  logic   out_valid; // Rail polarity
  round_t round;
  logic   alert;

  // Driven by one control rail
  modport rail (
    output in_ready,
    output out_valid,
    output round,
    output alert
  );

  // Read by the rail combiner
  modport comb (
    input in_ready,
    input out_valid,
    input round,
    input alert
  );

endinterface

//--- design/ctrl_cfg_regs.sv
// Cipher configuration register
// Latches operation and key length, maps key length to the AES round count

`timescale 1ns/10ps

module ctrl_cfg_regs import cipher_ctrl_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,

  input  logic     cfg_valid_i,
  input  ciph_op_e op_i,
  input  key_len_e key_len_i,

  output ciph_op_e op_o,
  output round_t   num_rounds_o
);

  round_t   num_rounds_d;
  ciph_op_e op_q;
  round_t   num_rounds_q;

  // Non one-hot codes fall back to the longest schedule
  always_comb begin
    case (key_len_i)
      AES_128: num_rounds_d = NumRounds128;
      AES_192: num_rounds_d = NumRounds192;
      AES_256: num_rounds_d = NumRounds256;
      default: num_rounds_d = NumRounds256;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      op_q         <= CIPH_FWD;
      num_rounds_q <= NumRounds128;
    end else if (cfg_valid_i) begin
      op_q         <= op_i;
      num_rounds_q <= num_rounds_d;
    end
  end

  assign op_o         = op_q;
  assign num_rounds_o = num_rounds_q;

endmodule

//--- design/sp2v_check.sv
// Sparse two-valued code checker
// Flags any input code other than SP2V_HIGH or SP2V_LOW

`timescale 1ns/10ps

module sp2v_check import cipher_ctrl_pkg::*; (
  input  sp2v_e sig_i,
  output logic  err_o
);

  // Only the two legal codes pass
  always_comb begin
    case (sig_i)
      SP2V_HIGH: err_o = 1'b0;
      SP2V_LOW:  err_o = 1'b0;
      default:   err_o = 1'b1;
    endcase
  end

endmodule

//--- design/ctrl_rail.sv
// Single-bit control rail for the AES round sequencer
// Runs the round FSM and counter for one bit of the sparse handshakes,
// with the bit polarity chosen by Inverted

`timescale 1ns/10ps

module ctrl_rail import cipher_ctrl_pkg::*; #(
  parameter bit Inverted = 1'b0
) (
  input  logic     clk_i,
  input  logic     rst_ni,

  input  logic     in_valid_i,  // Rail polarity
  input  logic     out_ready_i, // Rail polarity

  input  ciph_op_e op_i,
  input  round_t   num_rounds_i,
  input  logic     fault_i,

  rail_if.rail     rail_o
);

  rail_state_e state_d, state_q;
  round_t      rnd_d, rnd_q;
  round_t      nr_d, nr_q;
  ciph_op_e    op_d, op_q;

  logic in_valid, out_ready;
  logic in_ready, out_valid;
  logic last_rnd;

  // Undo the rail polarity on the way in
  assign in_valid  = in_valid_i ^ Inverted;
  assign out_ready = out_ready_i ^ Inverted;

  // Final round depends on the counting direction
  assign last_rnd = (op_q == CIPH_FWD) ? (rnd_q == nr_q) : (rnd_q == round_t'(1));

  ////////////////////
  // FSM
  ////////////////////

  always_comb begin
    state_d   = state_q;
    rnd_d     = rnd_q;
    nr_d      = nr_q;
    op_d      = op_q;
    in_ready  = 1'b0;
    out_valid = 1'b0;

    unique case (state_q)
      IDLE: begin
        in_ready = 1'b1;
        if (in_valid) begin
          op_d    = op_i;
          nr_d    = num_rounds_i;
          rnd_d   = (op_i == CIPH_FWD) ? round_t'(1) : num_rounds_i;
          state_d = ROUND;
        end
      end

      ROUND: begin
        if (last_rnd) begin
          state_d = FINISH; // Counter holds its last value
        end else if (op_q == CIPH_FWD) begin
          rnd_d = rnd_q + round_t'(1);
        end else begin
          rnd_d = rnd_q - round_t'(1);
        end
      end

      FINISH: begin
        out_valid = 1'b1;
        if (out_ready) begin
          rnd_d   = '0;
          state_d = IDLE;
        end
      end

      ERROR: begin
        // Terminal until reset
      end

      default: state_d = ERROR; // Corrupted state register
    endcase

    // Any fault overrides normal sequencing
    if (fault_i) begin
      state_d = ERROR;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      rnd_q   <= '0;
      nr_q    <= NumRounds128;
      op_q    <= CIPH_FWD;
    end else begin
      state_q <= state_d;
      rnd_q   <= rnd_d;
      nr_q    <= nr_d;
      op_q    <= op_d;
    end
  end

  // Outputs back in rail polarity
  assign rail_o.in_ready  = in_ready ^ Inverted;
  assign rail_o.out_valid = out_valid ^ Inverted;
  assign rail_o.round     = rnd_q;
  assign rail_o.alert     = (state_q == ERROR);

endmodule

//--- design/rail_combine.sv
// Control rail combiner
// Reassembles sparse handshake codes, votes the round counters and
// gathers all fault sources into one level fed back to the rails

`timescale 1ns/10ps

module rail_combine import cipher_ctrl_pkg::*; (
  rail_if.comb       rails_i [Sp2VWidth],
  input  logic [1:0] enc_err_i, // in_valid, out_ready checkers

  output sp2v_e      in_ready_o,
  output sp2v_e      out_valid_o,
  output round_t     round_o,
  output logic       alert_o,
  output logic       fault_o
);

  logic   [Sp2VWidth-1:0] sp_in_ready;
  logic   [Sp2VWidth-1:0] sp_out_valid;
  logic   [Sp2VWidth-1:0] mr_alert;
  round_t [Sp2VWidth-1:0] mr_round;

  logic mr_err;
  logic out_enc_err;

  // Flatten the interface array
  for (genvar i = 0; i < Sp2VWidth; i++) begin : gen_unpack
    assign sp_in_ready[i]  = rails_i[i].in_ready;
    assign sp_out_valid[i] = rails_i[i].out_valid;
    assign mr_alert[i]     = rails_i[i].alert;
    assign mr_round[i]     = rails_i[i].round;
  end

  assign in_ready_o  = sp2v_e'(sp_in_ready);
  assign out_valid_o = sp2v_e'(sp_out_valid);
  assign alert_o     = |mr_alert;

  // OR the counters, any rail differing from the result is a mismatch
  always_comb begin
    round_o = '0;
    mr_err  = 1'b0;
    for (int i = 0; i < Sp2VWidth; i++) begin
      round_o = round_o | mr_round[i];
    end
    for (int i = 0; i < Sp2VWidth; i++) begin
      if (mr_round[i] != round_o) begin
        mr_err = 1'b1;
      end
    end
  end

  // Disagreeing handshake bits show up as illegal codes
  assign out_enc_err = !(in_ready_o inside {SP2V_HIGH, SP2V_LOW}) ||
                       !(out_valid_o inside {SP2V_HIGH, SP2V_LOW});

  assign fault_o = mr_err | (|enc_err_i) | out_enc_err;

endmodule

//--- design/cipher_ctrl.sv
// AES cipher round sequencer, top level
// Redundant single-bit control rails behind sparse valid/ready handshakes

`timescale 1ns/10ps

module cipher_ctrl import cipher_ctrl_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,

  // Configuration
  input  logic     cfg_valid_i,
  input  ciph_op_e op_i,
  input  key_len_e key_len_i,

  // Job handshakes
  input  sp2v_e    in_valid_i,
  output sp2v_e    in_ready_o,
  output sp2v_e    out_valid_o,
  input  sp2v_e    out_ready_i,

  output round_t   round_o,
  output logic     alert_o
);

  ciph_op_e   op;
  round_t     num_rounds;
  logic [1:0] enc_err;
  logic       fault;

  rail_if rail_bus [Sp2VWidth] ();

  ctrl_cfg_regs u_cfg (
    .clk_i        ( clk_i       ),
    .rst_ni       ( rst_ni      ),
    .cfg_valid_i  ( cfg_valid_i ),
    .op_i         ( op_i        ),
    .key_len_i    ( key_len_i   ),
    .op_o         ( op          ),
    .num_rounds_o ( num_rounds  )
  );

  ////////////////////
  // Encoding checks
  ////////////////////

  sp2v_check u_in_valid_chk  ( .sig_i ( in_valid_i  ), .err_o ( enc_err[0] ) );
  sp2v_check u_out_ready_chk ( .sig_i ( out_ready_i ), .err_o ( enc_err[1] ) );

  // One rail per sparse bit, fed the raw input bits
  for (genvar i = 0; i < Sp2VWidth; i++) begin : gen_rail
    ctrl_rail #(
      .Inverted ( ~SP2V_LOGIC_HIGH[i] )
    ) u_rail (
      .clk_i        ( clk_i          ),
      .rst_ni       ( rst_ni         ),
      .in_valid_i   ( in_valid_i[i]  ),
      .out_ready_i  ( out_ready_i[i] ),
      .op_i         ( op             ),
      .num_rounds_i ( num_rounds     ),
      .fault_i      ( fault          ),
      .rail_o       ( rail_bus[i]    )
    );
  end

  rail_combine u_combine (
    .rails_i     ( rail_bus    ),
    .enc_err_i   ( enc_err     ),
    .in_ready_o  ( in_ready_o  ),
    .out_valid_o ( out_valid_o ),
    .round_o     ( round_o     ),
    .alert_o     ( alert_o     ),
    .fault_o     ( fault       )
  );

endmodule

//--- verification/cipher_ctrl_tb.sv
// Testbench for the AES cipher round sequencer
// Runs directed and random jobs against a small reference model, then injects faults

`timescale 1ns/10ps

module cipher_ctrl_tb import cipher_ctrl_pkg::*; ();

  logic     clk_i = 1'b0;
  logic     rst_ni;
  logic     cfg_valid_i;
  ciph_op_e op_i;
  key_len_e key_len_i;
  sp2v_e    in_valid_i;
  sp2v_e    in_ready_o;
  sp2v_e    out_valid_o;
  sp2v_e    out_ready_i;
  round_t   round_o;
  logic     alert_o;

  logic [31:0] lfsr;
  int          check_count;
  int          error_count;
  ciph_op_e    ref_op; // Model of the config register
  int          ref_nr;
  key_len_e    keys [3] = '{AES_128, AES_192, AES_256};

  cipher_ctrl cipher_ctrl_i (.*);

  initial begin
    forever #4 clk_i = ~clk_i;
  end

  ////////////////////
  // Always-on checks
  ////////////////////

  legal_codes_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (in_ready_o inside {SP2V_HIGH, SP2V_LOW}) && (out_valid_o inside {SP2V_HIGH, SP2V_LOW}))
  else begin
    $display("FAILED in_ready_o/out_valid_o: illegal codes %h/%h", in_ready_o, out_valid_o);
    error_count++;
  end

  alert_blocks_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    alert_o |-> (in_ready_o == SP2V_LOW && out_valid_o == SP2V_LOW))
  else begin
    $display("FAILED in_ready_o/out_valid_o under alert: %h/%h", in_ready_o, out_valid_o);
    error_count++;
  end

  alert_sticky_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $past(alert_o) |-> alert_o)
  else begin
    $display("FAILED alert_o: dropped to %h before reset", alert_o);
    error_count++;
  end

  ////////////////////
  // Helpers
  ////////////////////

  // Galois LFSR stepped once per bit
  function automatic logic next_bit();
    logic b;
    b    = lfsr[0];
    lfsr = lfsr >> 1;
    if (b) begin
      lfsr = lfsr ^ 32'h8020_0003;
    end
    return b;
  endfunction

  function automatic logic [7:0] rand_bits(input int n);
    logic [7:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[6:0], next_bit()};
    end
    return v;
  endfunction

  function automatic key_len_e rand_key_len();
    logic [7:0] sel;
    sel = rand_bits(2);
    if (sel == 8'd0) return AES_128;
    if (sel == 8'd1) return AES_192;
    if (sel == 8'd2) return AES_256;
    return key_len_e'(3'b101); // Not one-hot
  endfunction

  // AES round count with the long schedule for any other key length
  function automatic int rounds_for(input key_len_e kl);
    if (kl == AES_128) return 10;
    if (kl == AES_192) return 12;
    return 14;
  endfunction

  task automatic expect_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    check_count++;
    assert (got == exp) else begin
      $display("FAILED %s: got %h expected %h at %0t", name, got, exp, $time);
      error_count++;
    end
  endtask

  task automatic apply_reset();
    rst_ni = 1'b0;
    repeat (8) @(negedge clk_i);
    rst_ni = 1'b1;
    ref_op = CIPH_FWD;
    ref_nr = 10;
  endtask

  task automatic check_reset_state();
    expect_eq("in_ready_o", 32'(in_ready_o), 32'(SP2V_HIGH));
    expect_eq("out_valid_o", 32'(out_valid_o), 32'(SP2V_LOW));
    expect_eq("round_o", 32'(round_o), 32'd0);
    expect_eq("alert_o", 32'(alert_o), 32'd0);
  endtask

  task automatic wait_in_ready();
    int n;
    n = 0;
    while (in_ready_o != SP2V_HIGH && n < 50) begin
      @(negedge clk_i);
      n++;
    end
    if (in_ready_o != SP2V_HIGH) begin
      $display("Timeout while waiting for in_ready_o to go high");
      error_count++;
    end
  endtask

  task automatic wait_alert();
    int n;
    n = 0;
    while (alert_o !== 1'b1 && n < 10) begin
      @(negedge clk_i);
      n++;
    end
    if (alert_o !== 1'b1) begin
      $display("Timeout while waiting for alert_o after an invalid input code");
      error_count++;
    end
  endtask

  // Config takes effect one edge after the pulse
  task automatic configure(input ciph_op_e op, input key_len_e key_len);
    cfg_valid_i = 1'b1;
    op_i        = op;
    key_len_i   = key_len;
    @(negedge clk_i);
    cfg_valid_i = 1'b0;
    ref_op      = op;
    ref_nr      = rounds_for(key_len);
  endtask

  // One job with an optional config pulse in round 3
  task automatic run_job(input bit cfg_mid);
    ciph_op_e job_op;
    int       job_nr;
    int       stall;
    round_t   last;
    job_op = ref_op;
    job_nr = ref_nr;
    wait_in_ready();
    in_valid_i = SP2V_HIGH;
    @(negedge clk_i);
    in_valid_i = SP2V_LOW;
    for (int k = 1; k <= job_nr; k++) begin
      expect_eq("in_ready_o", 32'(in_ready_o), 32'(SP2V_LOW));
      expect_eq("out_valid_o", 32'(out_valid_o), 32'(SP2V_LOW));
      expect_eq("round_o", 32'(round_o), (job_op == CIPH_FWD) ? k : job_nr + 1 - k);
      if (cfg_mid && k == 3) begin
        cfg_valid_i = 1'b1;
        op_i        = (job_op == CIPH_FWD) ? CIPH_INV : CIPH_FWD;
        key_len_i   = AES_256;
        ref_op      = op_i;
        ref_nr      = rounds_for(AES_256);
      end else begin
        cfg_valid_i = 1'b0;
      end
      @(negedge clk_i);
    end
    last  = (job_op == CIPH_FWD) ? round_t'(job_nr) : round_t'(1);
    stall = int'(rand_bits(3));
    // Result held under back-pressure while stray in_valid pulses are ignored
    for (int s = 0; s <= stall; s++) begin
      expect_eq("out_valid_o", 32'(out_valid_o), 32'(SP2V_HIGH));
      expect_eq("in_ready_o", 32'(in_ready_o), 32'(SP2V_LOW));
      expect_eq("round_o", 32'(round_o), 32'(last));
      if (s < stall) begin
        out_ready_i = SP2V_LOW;
        in_valid_i  = next_bit() ? SP2V_HIGH : SP2V_LOW;
      end else begin
        out_ready_i = SP2V_HIGH;
        in_valid_i  = SP2V_LOW;
      end
      @(negedge clk_i);
    end
    out_ready_i = SP2V_LOW;
    expect_eq("out_valid_o", 32'(out_valid_o), 32'(SP2V_LOW));
    expect_eq("in_ready_o", 32'(in_ready_o), 32'(SP2V_HIGH));
    expect_eq("round_o", 32'(round_o), 32'd0);
  endtask

  // Bad code on in_valid while idle or on out_ready mid-job
  task automatic fault_test(input bit on_valid);
    if (on_valid) begin
      in_valid_i = sp2v_e'(3'b111);
      @(negedge clk_i);
      in_valid_i = SP2V_LOW;
    end else begin
      wait_in_ready();
      in_valid_i = SP2V_HIGH;
      @(negedge clk_i);
      in_valid_i = SP2V_LOW;
      repeat (2) @(negedge clk_i);
      out_ready_i = sp2v_e'(3'b000);
      @(negedge clk_i);
      out_ready_i = SP2V_LOW;
    end
    wait_alert();
    for (int i = 0; i < 30; i++) begin
      expect_eq("alert_o", 32'(alert_o), 32'd1);
      expect_eq("out_valid_o", 32'(out_valid_o), 32'(SP2V_LOW));
      expect_eq("in_ready_o", 32'(in_ready_o), 32'(SP2V_LOW));
      in_valid_i  = next_bit() ? SP2V_HIGH : SP2V_LOW;
      out_ready_i = SP2V_HIGH;
      @(negedge clk_i);
    end
    in_valid_i  = SP2V_LOW;
    out_ready_i = SP2V_LOW;
    apply_reset();
    check_reset_state();
  endtask

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    lfsr        = 32'h6d20;
    check_count = 0;
    error_count = 0;
    rst_ni      = 1'b0;
    cfg_valid_i = 1'b0;
    op_i        = CIPH_FWD;
    key_len_i   = AES_128;
    in_valid_i  = SP2V_LOW;
    out_ready_i = SP2V_LOW;
    apply_reset();
    check_reset_state();

    for (int i = 0; i < 6; i++) begin
      configure((i < 3) ? CIPH_FWD : CIPH_INV, keys[i % 3]);
      run_job(1'b0);
    end

    for (int i = 0; i < 10; i++) begin
      configure(next_bit() ? CIPH_INV : CIPH_FWD, rand_key_len());
      run_job(1'b0);
    end

    // Non one-hot key lengths and a config change during a job
    configure(CIPH_FWD, key_len_e'(3'b110));
    run_job(1'b0);
    configure(CIPH_INV, key_len_e'(3'b000));
    run_job(1'b0);
    configure(CIPH_FWD, AES_128);
    run_job(1'b1);
    run_job(1'b0);

    fault_test(1'b1);
    fault_test(1'b0);
    configure(CIPH_INV, AES_192);
    run_job(1'b0);

    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

//--- compile.f
design/cipher_ctrl_pkg.sv
design/rail_if.sv
design/ctrl_cfg_regs.sv
design/sp2v_check.sv
design/ctrl_rail.sv
design/rail_combine.sv
design/cipher_ctrl.sv
verification/cipher_ctrl_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the cipher_ctrl testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module cipher_ctrl_tb -f compile.f -o sim_cipher_ctrl
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim_cipher_ctrl)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qxF '** PASS **'; then
  exit 0
fi
exit 1
